// ==== design/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1c000000

// words per fetch line, also beats per read burst
`define FETCH_LINE_WORDS 4

// instruction buffer entries
// power of two, at least two lines deep
`define FETCH_IB_DEPTH 8

`endif

// ==== design/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

  // byte address and raw instruction
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // decode takes 0, 1 or 2 per cycle
  typedef logic [1:0] pop_num_t;

  // occupancy, one bit wider than the index so full fits
  typedef logic [$clog2(`FETCH_IB_DEPTH):0] ib_count_t;

  typedef enum logic [1:0] {
    line_idle,
    line_wait,
    line_hold
  } line_state_e;

  typedef enum logic [1:0] {
    br_idle,
    br_addr,
    br_data
  } bridge_state_e;

endpackage

// ==== design/pc_gen.sv ====
`include "fetch_config.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  logic  aclk,
  input  logic  rst_n,
  input  logic  redirect_valid,
  input  addr_t redirect_pc,
  output logic  req_valid,
  input  logic  req_ready,
  output addr_t req_pc
);

  localparam int line_bytes = `FETCH_LINE_WORDS * 4;

  addr_t next_line_pc;

  // next line boundary, also from an unaligned redirect target
  assign next_line_pc = (req_pc & ~addr_t'(line_bytes - 1)) + addr_t'(line_bytes);

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      req_pc    <= `FETCH_RESET_PC;
    end else begin
      // always something to fetch once out of reset
      req_valid <= 1'b1;
      if (redirect_valid) begin
        req_pc <= redirect_pc;
      end else if (req_valid && req_ready) begin
        req_pc <= next_line_pc;
      end
    end
  end

endmodule

// ==== design/line_fetch.sv ====
`include "fetch_config.svh"

module line_fetch
  import fetch_pkg::*;
(
  input  logic                                   aclk,
  input  logic                                   rst_n,
  input  logic                                   redirect_valid,
  input  logic                                   req_valid,
  output logic                                   req_ready,
  input  addr_t                                  req_pc,
  output logic                                   rd_valid,
  input  logic                                   rd_ready,
  output addr_t                                  rd_addr,
  input  logic                                   beat_valid,
  input  word_t                                  beat_data,
  input  logic                                   beat_last,
  output logic                                   push,
  output logic [$clog2(`FETCH_LINE_WORDS):0]     push_num,
  output addr_t                                  push_pc,
  output word_t [`FETCH_LINE_WORDS-1:0]          push_words,
  input  ib_count_t                              free_count
);

  localparam int off_w = $clog2(`FETCH_LINE_WORDS);

  line_state_e                  state;
  addr_t                        pc_q;
  word_t [`FETCH_LINE_WORDS-1:0] line_q;
  logic [off_w-1:0]             beat_cnt;
  logic [off_w-1:0]             offset;
  logic                         rd_pend;
  logic                         stale;
  logic                         fits;

  // word position of the request pc inside its line
  assign offset = pc_q[off_w+1:2];

  // no new line while a redirect is being taken
  assign req_ready = (state == line_idle) && !redirect_valid;

  assign rd_valid = rd_pend;
  assign rd_addr  = {pc_q[31:off_w+2], {(off_w + 2){1'b0}}};

  // words from the request pc to the end of the line
  assign push_num   = ($clog2(`FETCH_LINE_WORDS) + 1)'(`FETCH_LINE_WORDS) - {1'b0, offset};
  assign push_pc    = pc_q;
  assign push_words = line_q >> {offset, 5'b00000};

  assign fits = free_count >= ib_count_t'(push_num);
  assign push = (state == line_hold) && fits && !redirect_valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state    <= line_idle;
      rd_pend  <= 1'b0;
      stale    <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        line_idle: begin
          if (req_valid && req_ready) begin
            state    <= line_wait;
            rd_pend  <= 1'b1;
            stale    <= 1'b0;
            beat_cnt <= '0;
          end
        end
        line_wait: begin
          if (rd_valid && rd_ready) begin
            rd_pend <= 1'b0;
          end
          // burst still has to finish on the bus
          if (redirect_valid) begin
            stale <= 1'b1;
          end
          if (beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_last) begin
              state <= (stale || redirect_valid) ? line_idle : line_hold;
            end
          end
        end
        line_hold: begin
          // waits here for buffer room
          if (push || redirect_valid) begin
            state <= line_idle;
          end
        end
        default: state <= line_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (req_valid && req_ready) begin
      pc_q <= req_pc;
    end
    if (state == line_wait && beat_valid) begin
      line_q[beat_cnt] <= beat_data;
    end
  end

endmodule

// ==== design/instr_buffer.sv ====
`include "fetch_config.svh"

module instr_buffer
  import fetch_pkg::*;
(
  input  logic                               aclk,
  input  logic                               rst_n,
  input  logic                               flush,
  input  logic                               push,
  input  logic [$clog2(`FETCH_LINE_WORDS):0] push_num,
  input  addr_t                              push_pc,
  input  word_t [`FETCH_LINE_WORDS-1:0]      push_words,
  output ib_count_t                          free_count,
  input  pop_num_t                           pop,
  output pop_num_t                           inst_count,
  output word_t                              inst0,
  output addr_t                              pc0,
  output word_t                              inst1,
  output addr_t                              pc1
);

  localparam int depth = `FETCH_IB_DEPTH;
  localparam int aw    = $clog2(depth);

  word_t inst_mem [depth];
  addr_t pc_mem   [depth];

  logic [aw-1:0]                        head;
  logic [aw-1:0]                        tail;
  logic [aw-1:0]                        head_next;
  ib_count_t                            count;
  logic [$clog2(`FETCH_LINE_WORDS):0]   push_n;

  assign push_n     = push ? push_num : '0;
  assign free_count = ib_count_t'(depth) - count;

  // decode sees at most two
  assign inst_count = (count >= ib_count_t'(2)) ? pop_num_t'(2) : pop_num_t'(count);

  assign head_next = head + 1'b1;
  assign inst0     = inst_mem[head];
  assign pc0       = pc_mem[head];
  assign inst1     = inst_mem[head_next];
  assign pc1       = pc_mem[head_next];

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + aw'(pop);
      tail  <= tail + aw'(push_n);
      count <= count + ib_count_t'(push_n) - ib_count_t'(pop);
    end
  end

  // pointers wrap since depth is a power of two
  always_ff @(posedge aclk) begin
    if (push && !flush) begin
      for (int i = 0; i < `FETCH_LINE_WORDS; i++) begin
        if (i < push_num) begin
          inst_mem[tail + aw'(i)] <= push_words[i];
          pc_mem[tail + aw'(i)]   <= push_pc + addr_t'(4 * i);
        end
      end
    end
  end

endmodule

// ==== design/axi_read_bridge.sv ====
`include "fetch_config.svh"

module axi_read_bridge
  import fetch_pkg::*;
(
  input  logic  aclk,
  input  logic  rst_n,
  input  logic  rd_valid,
  output logic  rd_ready,
  input  addr_t rd_addr,
  output logic  beat_valid,
  output word_t beat_data,
  output logic  beat_last,
  output addr_t araddr,
  output logic  arvalid,
  input  logic  arready,
  input  word_t rdata,
  input  logic  rlast,
  input  logic  rvalid,
  output logic  rready
);

  bridge_state_e state;
  addr_t         addr_q;

  assign rd_ready = (state == br_idle);

  // address held steady from the register until arready
  assign arvalid = (state == br_addr);
  assign araddr  = addr_q;

  assign rready     = (state == br_data);
  assign beat_valid = rvalid && rready;
  assign beat_data  = rdata;
  assign beat_last  = rvalid && rready && rlast;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= br_idle;
    end else begin
      case (state)
        br_idle: begin
          if (rd_valid) begin
            state <= br_addr;
          end
        end
        br_addr: begin
          if (arready) begin
            state <= br_data;
          end
        end
        br_data: begin
          // one burst per line, done on the last beat
          if (rvalid && rlast) begin
            state <= br_idle;
          end
        end
        default: state <= br_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_valid && rd_ready) begin
      addr_q <= rd_addr;
    end
  end

endmodule

// ==== design/fetch_top.sv ====
`include "fetch_config.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic     aclk,
  input  logic     rst_n,
  output addr_t    araddr,
  output logic     arvalid,
  input  logic     arready,
  input  word_t    rdata,
  input  logic     rlast,
  input  logic     rvalid,
  output logic     rready,
  input  logic     redirect_valid,
  input  addr_t    redirect_pc,
  output pop_num_t inst_count,
  output word_t    inst0,
  output addr_t    pc0,
  output word_t    inst1,
  output addr_t    pc1,
  input  pop_num_t pop
);

  logic                               req_valid;
  logic                               req_ready;
  addr_t                              req_pc;
  logic                               rd_valid;
  logic                               rd_ready;
  addr_t                              rd_addr;
  logic                               beat_valid;
  word_t                              beat_data;
  logic                               beat_last;
  logic                               push;
  logic [$clog2(`FETCH_LINE_WORDS):0] push_num;
  addr_t                              push_pc;
  word_t [`FETCH_LINE_WORDS-1:0]      push_words;
  ib_count_t                          free_count;

  pc_gen i_pc_gen (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_pc         (req_pc)
  );

  line_fetch i_line_fetch (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_pc         (req_pc),
    .rd_valid       (rd_valid),
    .rd_ready       (rd_ready),
    .rd_addr        (rd_addr),
    .beat_valid     (beat_valid),
    .beat_data      (beat_data),
    .beat_last      (beat_last),
    .push           (push),
    .push_num       (push_num),
    .push_pc        (push_pc),
    .push_words     (push_words),
    .free_count     (free_count)
  );

  // a taken redirect also empties the buffer
  instr_buffer i_instr_buffer (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .flush      (redirect_valid),
    .push       (push),
    .push_num   (push_num),
    .push_pc    (push_pc),
    .push_words (push_words),
    .free_count (free_count),
    .pop        (pop),
    .inst_count (inst_count),
    .inst0      (inst0),
    .pc0        (pc0),
    .inst1      (inst1),
    .pc1        (pc1)
  );

  axi_read_bridge i_axi_read_bridge (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .rd_valid   (rd_valid),
    .rd_ready   (rd_ready),
    .rd_addr    (rd_addr),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready)
  );

endmodule

// ==== bench/fetch_properties.sv ====
`include "fetch_config.svh"

module fetch_properties
  import fetch_pkg::*;
(
  input logic      aclk,
  input logic      rst_n,
  input addr_t     araddr,
  input logic      arvalid,
  input logic      arready,
  input logic      rready,
  input ib_count_t count
);

  localparam int line_lsb = $clog2(`FETCH_LINE_WORDS) + 2;

  // set by any failing assertion, watched by the testbench
  logic failed;

  initial failed = 1'b0;

  a_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
  else begin
    failed = 1'b1;
    $error("arvalid dropped or araddr changed before arready");
  end

  a_ar_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid |-> araddr[line_lsb-1:0] == '0)
  else begin
    failed = 1'b1;
    $error("araddr not aligned to a line");
  end

  // data phase opens only on an accepted address
  a_rready_after_ar: assert property (@(posedge aclk) disable iff (!rst_n)
    $rose(rready) |-> $past(arvalid && arready))
  else begin
    failed = 1'b1;
    $error("rready raised without an accepted read address");
  end

  a_count_max: assert property (@(posedge aclk) disable iff (!rst_n)
    count <= ib_count_t'(`FETCH_IB_DEPTH))
  else begin
    failed = 1'b1;
    $error("buffer occupancy above its depth");
  end

endmodule

// bus checks on the bridge, only the occupancy check on the buffer
bind axi_read_bridge fetch_properties i_bridge_props (
  .aclk    (aclk),
  .rst_n   (rst_n),
  .araddr  (araddr),
  .arvalid (arvalid),
  .arready (arready),
  .rready  (rready),
  .count   ('0)
);

bind instr_buffer fetch_properties i_buffer_props (
  .aclk    (aclk),
  .rst_n   (rst_n),
  .araddr  ('0),
  .arvalid (1'b0),
  .arready (1'b0),
  .rready  (1'b0),
  .count   (count)
);

// ==== bench/fetch_tb.sv ====
`include "fetch_config.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int clk_period = 40;
  // five tests at worst-case slave delays need about 1600 cycles
  localparam int timeout_cycles = 4000;
  localparam word_t mem_pattern = 32'hA5A50000;

  logic     aclk;
  logic     rst_n;
  addr_t    araddr;
  logic     arvalid;
  logic     arready;
  word_t    rdata;
  logic     rlast;
  logic     rvalid;
  logic     rready;
  logic     redirect_valid;
  addr_t    redirect_pc;
  pop_num_t inst_count;
  word_t    inst0;
  addr_t    pc0;
  word_t    inst1;
  addr_t    pc1;
  pop_num_t pop;

  logic [31:0] lcg_state = 32'h4292;
  int          beat_gap_max = 3;
  int          cycle_count = 0;
  addr_t       exp_pc;

  fetch_top i_dut (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rlast          (rlast),
    .rvalid         (rvalid),
    .rready         (rready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .inst_count     (inst_count),
    .inst0          (inst0),
    .pc0            (pc0),
    .inst1          (inst1),
    .pc1            (pc1),
    .pop            (pop)
  );

  initial begin
    aclk = 1'b0;
    forever #(clk_period / 2) aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // upper half, low bits of an lcg repeat quickly
    return {16'h0000, lcg_state[31:16]};
  endfunction

  // memory contents
  function automatic word_t mem_word(input addr_t a);
    return a ^ mem_pattern;
  endfunction

  function automatic logic props_failed();
    return i_dut.i_axi_read_bridge.i_bridge_props.failed ||
           i_dut.i_instr_buffer.i_buffer_props.failed;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_pc(input addr_t actual, input addr_t expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic check_count(input pop_num_t actual, input pop_num_t expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected));
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected));
    end
  endtask

  task automatic step();
    @(posedge aclk);
    #2;
  endtask

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run("timeout: the tests did not finish within the cycle limit");
    end
    if (props_failed()) begin
      abort_run("a bound assertion on the AXI or buffer behavior failed");
    end
  end

  // AXI slave, one four-beat burst at a time
  initial begin : axi_slave
    int unsigned gap;
    addr_t       base;
    logic        ready_seen;
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rdata   = '0;
    forever begin
      step();
      if (rst_n && arvalid) begin
        gap = lcg_next() % 4;
        repeat (gap) step();
        base    = araddr;
        arready = 1'b1;
        step();
        arready = 1'b0;
        for (int i = 0; i < `FETCH_LINE_WORDS; i++) begin
          gap = lcg_next() % (beat_gap_max + 1);
          repeat (gap) step();
          rvalid = 1'b1;
          rdata  = mem_word(base + addr_t'(4 * i));
          rlast  = (i == `FETCH_LINE_WORDS - 1);
          // rready only changes at an edge, so this predicts the transfer
          do begin
            ready_seen = rready;
            step();
          end while (!ready_seen);
          rvalid = 1'b0;
          rlast  = 1'b0;
        end
      end
    end
  end

  // pops n words, each checked against the running expected pc
  task automatic drain_words(input int n, input bit random_count);
    int       popped;
    pop_num_t take;
    popped = 0;
    while (popped < n) begin
      step();
      take = inst_count;
      if (random_count) begin
        take = pop_num_t'(lcg_next() % (inst_count + 1));
      end
      if (int'(take) > n - popped) begin
        take = pop_num_t'(n - popped);
      end
      if (take >= 1) begin
        check_pc(pc0, exp_pc, "pc0");
        check_word(inst0, mem_word(exp_pc), "inst0");
      end
      if (take == 2) begin
        check_pc(pc1, exp_pc + 4, "pc1");
        check_word(inst1, mem_word(exp_pc + 4), "inst1");
      end
      pop    = take;
      popped = popped + int'(take);
      exp_pc = exp_pc + addr_t'(4 * take);
    end
    step();
    pop = '0;
  endtask

  task automatic redirect_to(input addr_t target);
    redirect_valid = 1'b1;
    redirect_pc    = target;
    step();
    redirect_valid = 1'b0;
    exp_pc         = target;
  endtask

  task automatic sequential_fetch();
    drain_words(32, 1'b0);
  endtask

  task automatic backpressure_hold();
    repeat (120) step();
    repeat (80) begin
      step();
      check_count(inst_count, 2'd2, "inst_count while stalled");
      check_flag(arvalid, 1'b0, "arvalid with a full buffer");
    end
    drain_words(16, 1'b0);
  endtask

  task automatic unaligned_redirect();
    redirect_to(32'h1c000238);
    drain_words(14, 1'b0);
  endtask

  task automatic redirect_in_burst();
    beat_gap_max = 8;
    redirect_to(32'h1c000400);
    // data phase of the new line, not of an older stale one
    do begin
      step();
    end while (!(rready && araddr == 32'h1c000400));
    redirect_to(32'h1c000824);
    drain_words(10, 1'b0);
    beat_gap_max = 3;
  endtask

  task automatic random_pops();
    addr_t target;
    repeat (4) begin
      target = `FETCH_RESET_PC | (addr_t'(lcg_next()) & 32'h0000fffc);
      redirect_to(target);
      drain_words(24, 1'b1);
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    pop            = '0;
    exp_pc         = `FETCH_RESET_PC;
    repeat (5) @(posedge aclk);
    #2;
    rst_n = 1'b1;
    check_flag(arvalid, 1'b0, "arvalid after reset");
    check_count(inst_count, 2'd0, "inst_count after reset");
    sequential_fetch();
    backpressure_hold();
    unaligned_redirect();
    redirect_in_burst();
    random_pops();
    step();
    if (props_failed()) begin
      abort_run("a bound assertion on the AXI or buffer behavior failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
+incdir+design
design/fetch_pkg.sv
design/pc_gen.sv
design/line_fetch.sv
design/instr_buffer.sv
design/axi_read_bridge.sv
design/fetch_top.sv
bench/fetch_properties.sv
bench/fetch_tb.sv
